// File: fabric_ctrl.sv
// Fabric sequencer
// Steps through receive, route and transmit while packets are waiting

module fabric_ctrl (
  input  logic                      clk,
  input  logic                      rst_n,
  input  switch_pkg::port_mask_t    fifo_ready,
  input  switch_pkg::port_mask_t    held,
  output switch_pkg::fabric_state_t state
);

  import switch_pkg::*;

  fabric_state_t next_state;
  logic          work;

  // Something buffered or something still held
  assign work = (|fifo_ready) || (|held);

  // --------------------------------------------------------------------------
  // Next state
  // --------------------------------------------------------------------------

  always_comb begin
    next_state = state;
    case (state)
      st_idle:     if (work) next_state = st_receive;
      st_receive:  next_state = st_route;
      st_route:    next_state = st_transmit;
      // Back to receive while work remains
      st_transmit: next_state = work ? st_receive : st_idle;
      default:     next_state = st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_idle;
    end else begin
      state <= next_state;
    end
  end

endmodule

// File: ingress_fifo.sv
// Ingress path for one input port
// Checks each offered packet and buffers the accepted ones in order
// Head shows the oldest buffered packet

module ingress_fifo (
  input  logic             clk,
  input  logic             rst_n,
  input  switch_pkg::port_t port_in,
  input  logic             pop,
  output switch_pkg::port_t head
);

  import switch_pkg::*;

  // --------------------------------------------------------------------------
  // Validation
  // --------------------------------------------------------------------------

  logic pkt_ok;
  logic full;
  logic wr_en;
  logic rd_en;

  // Sender must be one-hot and at least one target set
  // A target may include the sender only for a broadcast
  assign pkt_ok = $onehot(port_in.pkt.src)
               && (|port_in.pkt.tgt)
               && ((port_in.pkt.tgt == broadcast_target)
                   || ((port_in.pkt.tgt & port_in.pkt.src) == '0));

  // Rejected or overflowing packets are dropped, no back-pressure
  assign wr_en = port_in.valid && pkt_ok && !full;

  // --------------------------------------------------------------------------
  // Circular buffer
  // --------------------------------------------------------------------------

  pkt_t                      mem [fifo_depth];
  logic [fifo_ptr_width-1:0] wr_ptr;
  logic [fifo_ptr_width-1:0] rd_ptr;
  logic [fifo_cnt_width-1:0] count;

  assign full  = (count == fifo_cnt_width'(fifo_depth));
  assign rd_en = pop && head.valid;

  // Oldest entry, valid whenever something is stored
  assign head.valid = (count != '0);
  assign head.pkt   = mem[rd_ptr];

  // Storage, written only for accepted packets
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= port_in.pkt;
    end
  end

  // Pointers wrap by overflow, depth is a power of two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;   // Idle or simultaneous push and pop
      endcase
    end
  end

endmodule

// File: output_arbiter.sv
// Round-robin arbiter and data select for one output port
// Picks among the inputs whose held packet still targets this output

module output_arbiter (
  input  logic                      clk,
  input  logic                      rst_n,
  input  switch_pkg::fabric_state_t state,
  input  switch_pkg::port_mask_t    req,
  input  switch_pkg::port_t         cand [switch_pkg::num_ports],
  output switch_pkg::port_mask_t    gnt,
  output switch_pkg::port_t         port_out
);

  import switch_pkg::*;

  logic [grant_width-1:0] ptr;
  logic [grant_width-1:0] sel;
  logic [grant_width-1:0] idx;
  logic                   found;

  // --------------------------------------------------------------------------
  // Search from the pointer, wrapping past the last input
  // --------------------------------------------------------------------------

  always_comb begin
    found = 1'b0;
    sel   = ptr;
    idx   = ptr;
    for (int k = 0; k < num_ports; k++) begin
      // Two-bit sum wraps modulo four
      idx = ptr + k[grant_width-1:0];
      if (!found && req[idx]) begin
        found = 1'b1;
        sel   = idx;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Grant and output drive
  // --------------------------------------------------------------------------

  // Grant only inside the transmit window
  always_comb begin
    gnt = '0;
    if ((state == st_transmit) && found) begin
      gnt[sel] = 1'b1;
    end
  end

  // Idle output carries an all-zero packet
  always_comb begin
    port_out = '0;
    if (|gnt) begin
      port_out.valid = 1'b1;
      port_out.pkt   = cand[sel].pkt;
    end
  end

  // Pointer moves past the winner only when a packet actually left
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ptr <= '0;
    end else if (|gnt) begin
      ptr <= sel + 1'b1;
    end
  end

endmodule

// File: packet_holder.sv
// Current packet register for one input
// Keeps the packet until every output in its target mask has taken it
// and pulls the next one from the ingress FIFO

module packet_holder (
  input  logic                      clk,
  input  logic                      rst_n,
  input  switch_pkg::fabric_state_t state,
  input  switch_pkg::port_t         head,
  input  switch_pkg::port_mask_t    served,
  output logic                      pop,
  output switch_pkg::port_t         cur,
  output switch_pkg::port_mask_t    pending
);

  import switch_pkg::*;

  logic       cur_valid;
  pkt_t       cur_pkt;
  port_mask_t served_q;
  logic       done;

  // --------------------------------------------------------------------------
  // Status
  // --------------------------------------------------------------------------

  // All targets covered by the outputs that already took the packet
  assign done = cur_valid && ((cur_pkt.tgt & ~served_q) == '0);

  // Outputs still to be reached, zero while nothing is held
  assign pending = cur_valid ? (cur_pkt.tgt & ~served_q) : '0;

  assign cur.valid = cur_valid;
  assign cur.pkt   = cur_pkt;

  // Load slot is the receive phase only
  assign pop = (state == st_receive) && (!cur_valid || done) && head.valid;

  // --------------------------------------------------------------------------
  // Control state
  // --------------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cur_valid <= 1'b0;
      served_q  <= '0;
    end else if (pop) begin
      // New packet, no output has seen it yet
      cur_valid <= 1'b1;
      served_q  <= '0;
    end else if (done && !head.valid) begin
      // Finished and nothing behind it
      cur_valid <= 1'b0;
      served_q  <= '0;
    end else begin
      // Grants only arrive in transmit
      served_q <= served_q | served;
    end
  end

  // --------------------------------------------------------------------------
  // Payload
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (pop) begin
      cur_pkt <= head.pkt;
    end
  end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the switch testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_switch_4port \
  -f sim.f -o sim_switch \
  && ./obj_dir/sim_switch > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }

cat sim.log
grep -qx "PASS: all tests" sim.log && exit 0 || exit 1

// File: sim.f
switch_pkg.sv
ingress_fifo.sv
packet_holder.sv
output_arbiter.sv
fabric_ctrl.sv
switch_4port.sv
switch_4port_asserts.sv
tb_switch_4port.sv

// File: switch_4port.sv
// Four-port packet switch fabric
// Per-input ingress FIFO and packet holder, per-output round-robin arbiter,
// one sequencer that opens the transmit window

module switch_4port (
  input  logic              clk,
  input  logic              rst_n,
  input  switch_pkg::port_t port_in  [switch_pkg::num_ports],
  output switch_pkg::port_t port_out [switch_pkg::num_ports]
);

  import switch_pkg::*;

  // --------------------------------------------------------------------------
  // Internal wiring
  // --------------------------------------------------------------------------

  fabric_state_t state;

  // Per input
  port_t      head    [num_ports];
  logic       pop     [num_ports];
  port_t      cur     [num_ports];
  port_mask_t pending [num_ports];   // Indexed by output
  port_mask_t served  [num_ports];   // Indexed by output

  // Per output
  port_mask_t req [num_ports];       // Indexed by input
  port_mask_t gnt [num_ports];       // Indexed by input

  // Sequencer status
  port_mask_t fifo_ready;
  port_mask_t held;

  // --------------------------------------------------------------------------
  // Input side
  // --------------------------------------------------------------------------

  for (genvar i = 0; i < num_ports; i++) begin : g_in
    ingress_fifo u_fifo (
      .clk     (clk),
      .rst_n   (rst_n),
      .port_in (port_in[i]),
      .pop     (pop[i]),
      .head    (head[i])
    );

    packet_holder u_holder (
      .clk     (clk),
      .rst_n   (rst_n),
      .state   (state),
      .head    (head[i]),
      .served  (served[i]),
      .pop     (pop[i]),
      .cur     (cur[i]),
      .pending (pending[i])
    );

    assign fifo_ready[i] = head[i].valid;
    assign held[i]       = cur[i].valid;
  end

  // --------------------------------------------------------------------------
  // Request and grant transpose
  // --------------------------------------------------------------------------

  // Input i asks output j when bit j of its pending mask is set
  // and output j marks input i as served through bit i of its grant
  always_comb begin
    for (int i = 0; i < num_ports; i++) begin
      for (int j = 0; j < num_ports; j++) begin
        req[j][i]    = pending[i][j];
        served[i][j] = gnt[j][i];
      end
    end
  end

  // --------------------------------------------------------------------------
  // Output side
  // --------------------------------------------------------------------------

  for (genvar j = 0; j < num_ports; j++) begin : g_out
    output_arbiter u_arb (
      .clk      (clk),
      .rst_n    (rst_n),
      .state    (state),
      .req      (req[j]),
      .cand     (cur),
      .gnt      (gnt[j]),
      .port_out (port_out[j])
    );
  end

  // --------------------------------------------------------------------------
  // Sequencer
  // --------------------------------------------------------------------------

  fabric_ctrl u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .fifo_ready (fifo_ready),
    .held       (held),
    .state      (state)
  );

endmodule

// File: switch_4port_asserts.sv
// Output checks for the switch fabric
// Bound into the top level, watches the four output ports

module switch_4port_asserts (
  input logic              clk,
  input logic              rst_n,
  input switch_pkg::port_t port_out [switch_pkg::num_ports]
);

  timeunit 1ns;
  timeprecision 100ps;

  import switch_pkg::*;

  for (genvar j = 0; j < num_ports; j++) begin : g_port
    // One delivery per round, a round takes three cycles
    a_spacing: assert property (@(posedge clk) disable iff (!rst_n)
      port_out[j].valid |-> !$past(port_out[j].valid) && !$past(port_out[j].valid, 2))
      else $error("Output %0d valid again within three cycles", j);

    // Idle output carries no data
    a_idle_zero: assert property (@(posedge clk) disable iff (!rst_n)
      !port_out[j].valid |-> (port_out[j].pkt == '0))
      else $error("Output %0d has data while not valid", j);

    // Quiet right after reset
    a_reset_quiet: assert property (@(posedge clk)
      $rose(rst_n) |-> !port_out[j].valid)
      else $error("Output %0d valid in the first cycle after reset", j);
  end

endmodule

bind switch_4port switch_4port_asserts u_asserts (
  .clk      (clk),
  .rst_n    (rst_n),
  .port_out (port_out)
);

// File: switch_pkg.sv
// Shared definitions for the four-port packet switch fabric
// Widths, packet and port structs, fabric state encoding

package switch_pkg;

  // --------------------------------------------------------------------------
  // Sizes
  // --------------------------------------------------------------------------

  // Port count is fixed, the target mask has one bit per port
  localparam int num_ports   = 4;
  localparam int data_width  = 8;
  localparam int grant_width = 2;

  // Ingress buffering per input
  localparam int fifo_depth     = 8;
  localparam int fifo_ptr_width = $clog2(fifo_depth);
  // One extra bit so that a full FIFO can be counted
  localparam int fifo_cnt_width = fifo_ptr_width + 1;

  // --------------------------------------------------------------------------
  // Packet types
  // --------------------------------------------------------------------------

  // One bit per port, bit i stands for port i
  typedef logic [num_ports-1:0] port_mask_t;

  // Target mask with every port set
  localparam port_mask_t broadcast_target = '1;

  // Packet as it travels through the fabric
  typedef struct packed {
    port_mask_t            src;   // One-hot sender
    port_mask_t            tgt;   // Destination mask
    logic [data_width-1:0] data;
  } pkt_t;

  // Packet with its qualifier
  // Used on the ports, at a FIFO head and for a held packet
  typedef struct packed {
    logic valid;
    pkt_t pkt;
  } port_t;

  // --------------------------------------------------------------------------
  // Fabric sequencing
  // --------------------------------------------------------------------------

  // Round of receive, route, transmit; idle when there is no work
  typedef enum logic [1:0] {
    st_idle     = 2'b00,
    st_receive  = 2'b01,
    st_route    = 2'b10,
    st_transmit = 2'b11
  } fabric_state_t;

endpackage

// File: tb_switch_4port.sv
// Testbench for the four-port switch fabric
// Table-driven stimulus, scoreboard per output and input, drain wait and watchdog

module tb_switch_4port;

  timeunit 1ns;
  timeprecision 100ps;

  import switch_pkg::*;

  // ---------------------------------------------------------------------------
  // Constants, table and scoreboard
  // ---------------------------------------------------------------------------

  localparam int clk_period   = 40;
  localparam int num_tests    = 6;
  localparam int quiet_limit  = 12;   // Idle output cycles that end a test
  localparam int drain_window = quiet_limit + 3 * fifo_depth * num_ports;
  localparam int ovf_len      = 14;   // Burst long enough to overrun one FIFO
  localparam int rand_rows    = 60;
  localparam int rand_cap     = 6;    // Packets per input, stays below FIFO depth

  // One row is one clock of traffic on all four inputs
  typedef struct packed {
    logic [2:0]            test;
    port_t [num_ports-1:0] lane;
  } row_t;

  // Expected sources at output 0 in the round-robin test
  int    rr_order [6] = '{1, 2, 3, 1, 2, 3};
  string test_name [num_tests] = '{"unicast", "multicast", "invalid", "round-robin",
                                   "overflow", "random"};

  logic  clk = 1'b0;
  logic  rst_n = 1'b0;
  port_t port_in  [num_ports];
  port_t port_out [num_ports];

  row_t  stim [$];
  pkt_t  exp_q [num_ports][num_ports][$];   // Output, then source input
  int    order_out0 [$];
  bit    ovf_acc [$];                       // Burst packets that find room
  int    seed = 59760;
  int    errors = 0;
  int    failed_tests = 0;
  int    quiet_cycles = 0;
  int    watchdog_ns = 0;
  bit    table_ready = 1'b0;

  always #(clk_period / 2) clk = ~clk;

  switch_4port DUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .port_in  (port_in),
    .port_out (port_out)
  );

  // ---------------------------------------------------------------------------
  // Helpers
  // ---------------------------------------------------------------------------

  // Ingress acceptance rule
  function automatic bit passes_validation(pkt_t p);
    bit one_hot;
    one_hot = (p.src != '0) && ((p.src & (p.src - 1'b1)) == '0);
    return one_hot && (p.tgt != '0)
        && ((p.tgt == broadcast_target) || ((p.tgt & p.src) == '0));
  endfunction

  function automatic int src_index(port_mask_t m);
    int idx;
    idx = -1;
    for (int i = 0; i < num_ports; i++) begin
      if (m == port_mask_t'(1 << i)) begin
        idx = i;
      end
    end
    return idx;
  endfunction

  function automatic port_t offer(port_mask_t src, port_mask_t tgt,
                                  logic [data_width-1:0] data);
    port_t p;
    p.valid    = 1'b1;
    p.pkt.src  = src;
    p.pkt.tgt  = tgt;
    p.pkt.data = data;
    return p;
  endfunction

  task automatic compare_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
    if (got !== exp) begin
      $display("ERR %0d ns: %s, got %0h, expected %0h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic add_row(input int t, input port_t l0, input port_t l1,
                         input port_t l2, input port_t l3);
    row_t r;
    r.test    = 3'(t);
    r.lane[0] = l0;
    r.lane[1] = l1;
    r.lane[2] = l2;
    r.lane[3] = l3;
    stim.push_back(r);
  endtask

  // ---------------------------------------------------------------------------
  // Stimulus table
  // ---------------------------------------------------------------------------

  task automatic build_table();
    row_t       row;
    int         rnd;
    int         sent [num_ports];
    port_mask_t src;
    port_mask_t tgt;
    // Each input to a different output
    add_row(1, offer(4'b0001, 4'b0010, 8'h11), offer(4'b0010, 4'b0100, 8'h22),
               offer(4'b0100, 4'b1000, 8'h33), offer(4'b1000, 4'b0001, 8'h44));
    // Two targets, and a broadcast that returns to its sender
    add_row(2, offer(4'b0001, 4'b0110, 8'h5a), offer(4'b0010, broadcast_target, 8'ha5),
               '0, '0);
    // Bad source, zero source, zero target, self target
    add_row(3, offer(4'b0011, 4'b0100, 8'h01), offer(4'b0000, 4'b0001, 8'h02),
               offer(4'b0100, 4'b0000, 8'h03), offer(4'b1000, 4'b1001, 8'h04));
    add_row(3, '0, '0, '0, offer(4'b1000, 4'b0001, 8'h05));
    // Three inputs compete for output 0 twice
    add_row(4, '0, offer(4'b0010, 4'b0001, 8'h41), offer(4'b0100, 4'b0001, 8'h42),
               offer(4'b1000, 4'b0001, 8'h43));
    add_row(4, '0, offer(4'b0010, 4'b0001, 8'h51), offer(4'b0100, 4'b0001, 8'h52),
               offer(4'b1000, 4'b0001, 8'h53));
    for (int r = 0; r < ovf_len; r++) begin
      add_row(5, offer(4'b0001, 4'b0010, 8'(8'h80 + r)), '0, '0, '0);
    end
    // Sparse random traffic, legal packets only
    for (int p = 0; p < num_ports; p++) begin
      sent[p] = 0;
    end
    for (int r = 0; r < rand_rows; r++) begin
      row.test = 3'd6;
      for (int p = 0; p < num_ports; p++) begin
        rnd = $random(seed);
        src = port_mask_t'(1 << p);
        tgt = rnd[7:4] & ~src;
        if (tgt == '0) begin
          tgt = broadcast_target;
        end
        row.lane[p] = '0;
        if ((rnd[2:0] == 3'd0) && (sent[p] < rand_cap)) begin
          row.lane[p] = offer(src, tgt, rnd[15:8]);
          sent[p]++;
        end
      end
      stim.push_back(row);
    end
    // Rows plus per test reset, idle row and drain, with a factor of two
    watchdog_ns = (stim.size() + num_tests * (drain_window + 4)) * clk_period * 2;
  endtask

  // ---------------------------------------------------------------------------
  // Cycle model of one input bursting to one output from reset
  // ---------------------------------------------------------------------------

  task automatic model_overflow(input int n);
    fabric_state_t st;
    int            cnt;
    bit            held;
    bit            done;
    bit            wr;
    bit            pop;
    bit            work;
    ovf_acc.delete();
    st   = st_idle;
    cnt  = 0;
    held = 1'b0;
    done = 1'b0;
    for (int k = 0; k < n; k++) begin
      work = (cnt > 0) || held;
      wr   = (cnt < fifo_depth);
      pop  = (st == st_receive) && (!held || done) && (cnt > 0);
      ovf_acc.push_back(wr);
      if (pop) begin
        held = 1'b1;
        done = 1'b0;
      end else if (done && (cnt == 0)) begin
        held = 1'b0;
        done = 1'b0;
      end else if ((st == st_transmit) && held) begin
        done = 1'b1;   // Single target, one transmit finishes it
      end
      cnt = cnt + int'(wr) - int'(pop);
      case (st)
        st_receive: st = st_route;
        st_route:   st = st_transmit;
        default:    st = work ? st_receive : st_idle;
      endcase
    end
  endtask

  // ---------------------------------------------------------------------------
  // Monitor, samples mid-cycle
  // ---------------------------------------------------------------------------

  task automatic take_delivery(input int j, input pkt_t got);
    int   i;
    pkt_t exp;
    i = src_index(got.src);
    if (i < 0) begin
      $display("Output %0d delivered a packet with a broken source mask %b", j, got.src);
      errors++;
    end else if (exp_q[j][i].size() == 0) begin
      $display("Output %0d delivered a packet from input %0d that was never expected", j, i);
      errors++;
    end else begin
      exp = exp_q[j][i].pop_front();
      compare_value(32'(got), 32'(exp), $sformatf("packet at output %0d from input %0d", j, i));
      if (j == 0) begin
        order_out0.push_back(i);
      end
    end
  endtask

  always @(negedge clk) begin
    logic busy;
    busy = 1'b0;
    if (rst_n) begin
      for (int j = 0; j < num_ports; j++) begin
        if (port_out[j].valid) begin
          busy = 1'b1;
          take_delivery(j, port_out[j].pkt);
        end
      end
      quiet_cycles = busy ? 0 : quiet_cycles + 1;
    end
  end

  // ---------------------------------------------------------------------------
  // Test sequencing
  // ---------------------------------------------------------------------------

  task automatic reset_dut();
    @(posedge clk);
    #2;
    rst_n = 1'b0;
    for (int j = 0; j < num_ports; j++) begin
      for (int i = 0; i < num_ports; i++) begin
        exp_q[j][i].delete();
      end
    end
    order_out0.delete();
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;
  endtask

  task automatic run_test(input int t);
    int err_before;
    int n;
    bit take;
    err_before = errors;
    reset_dut();
    if (t == 5) begin
      model_overflow(ovf_len);
    end
    n = 0;
    foreach (stim[r]) begin
      if (int'(stim[r].test) == t) begin
        @(posedge clk);
        #2;
        for (int p = 0; p < num_ports; p++) begin
          port_in[p] = stim[r].lane[p];
          take = stim[r].lane[p].valid && passes_validation(stim[r].lane[p].pkt);
          // Burst packets that meet a full FIFO are lost
          if ((t == 5) && (p == 0)) begin
            take = take && ovf_acc[n];
          end
          if (take) begin
            for (int j = 0; j < num_ports; j++) begin
              if (stim[r].lane[p].pkt.tgt[j]) begin
                exp_q[j][src_index(stim[r].lane[p].pkt.src)].push_back(stim[r].lane[p].pkt);
              end
            end
          end
        end
        n++;
      end
    end
    @(posedge clk);
    #2;
    for (int p = 0; p < num_ports; p++) begin
      port_in[p] = '0;
    end
    quiet_cycles = 0;
    while (quiet_cycles < quiet_limit) begin
      @(posedge clk);
    end
    for (int j = 0; j < num_ports; j++) begin
      for (int i = 0; i < num_ports; i++) begin
        compare_value(exp_q[j][i].size(), 0,
                      $sformatf("undelivered packets at output %0d from input %0d", j, i));
      end
    end
    if (t == 4) begin
      compare_value(order_out0.size(), $size(rr_order), "deliveries at output 0");
      for (int k = 0; (k < $size(rr_order)) && (k < order_out0.size()); k++) begin
        compare_value(order_out0[k], rr_order[k], $sformatf("source of delivery %0d", k));
      end
    end
    if (errors == err_before) begin
      $display("Test %0d (%s) ok", t, test_name[t - 1]);
    end else begin
      failed_tests++;
      $display("Test %0d (%s) had %0d errors", t, test_name[t - 1], errors - err_before);
    end
  endtask

  initial begin
    for (int p = 0; p < num_ports; p++) begin
      port_in[p] = '0;
    end
    rst_n = 1'b0;
    build_table();
    table_ready = 1'b1;
    for (int t = 1; t <= num_tests; t++) begin
      run_test(t);
    end
    $display("Summary: %0d tests, %0d failed, %0d errors", num_tests, failed_tests, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (table_ready);
    #(watchdog_ns);
    $display("Timeout: the tests did not finish within %0d ns", watchdog_ns);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule
